//--- all.f
+incdir+common
common/timer_pkg.sv
design/tick_gen.sv
button/button_cond.sv
design/run_ctrl.sv
counter/bcd_downcounter.sv
display/seg_scan.sv
design/countdown_top.sv
sim/countdown_props.sv
sim/countdown_tb.sv

//--- button/button_cond.sv
`include "timer_defines.svh"

module button_cond (
    input  logic clk,
    input  logic rst_p,
    input  logic sample_tick,
    input  logic pb,
    output logic press
);

    localparam int unsigned DEB_LEN = `TIMER_DEB_LEN;
    localparam int unsigned CNT_W   = $clog2(DEB_LEN + 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] run_cnt;
    logic             deb_level;
    logic             deb_prev;

    // Two-flop synchronizer
    always_ff @(posedge clk) begin
        if (rst_p) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], pb};
        end
    end

    //////////////////////////////
    // Debounce
    //////////////////////////////

    // Counts samples that disagree with the current level
    always_ff @(posedge clk) begin
        if (rst_p) begin
            run_cnt   <= '0;
            deb_level <= 1'b0;
        end else if (sample_tick) begin
            if (sync_q[1] == deb_level) begin
                run_cnt <= '0;
            end else if (run_cnt == CNT_W'(DEB_LEN - 1)) begin
                run_cnt   <= '0;
                deb_level <= sync_q[1];
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

    // One pulse on the rising edge
    always_ff @(posedge clk) begin
        if (rst_p) begin
            deb_prev <= 1'b0;
        end else begin
            deb_prev <= deb_level;
        end
    end

    assign press = deb_level & ~deb_prev;

endmodule

//--- common/timer_defines.svh
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

//////////////////////////////
// Clock dividers
//////////////////////////////

// Cycles per one-second strobe
`define TIMER_SEC_DIV     100000000
// Cycles per button sample
`define TIMER_SAMPLE_DIV  1000000
// Cycles per displayed digit
`define TIMER_SCAN_DIV    100000

// Equal samples needed to move the debounced level
`define TIMER_DEB_LEN     4

// Start value of the countdown
`define TIMER_START_TENS  3
`define TIMER_START_ONES  0

// Display geometry
`define TIMER_DIGITS      4
`define TIMER_SEG_W       8
`define TIMER_LEDS        16

`endif

//--- common/timer_pkg.sv
`include "timer_defines.svh"

package timer_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    // One decimal digit
    typedef logic [3:0] bcd_t;

    // Segments a..g then dp, active low
    typedef logic [`TIMER_SEG_W-1:0] seg_t;

    // Digit enables, active low
    typedef logic [`TIMER_DIGITS-1:0] dis_t;

    typedef logic [`TIMER_LEDS-1:0] led_t;

    //////////////////////////////
    // Run control
    //////////////////////////////

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        PAUSE = 2'd2,
        DONE  = 2'd3
    } run_state_t;

endpackage

//--- counter/bcd_downcounter.sv
module bcd_downcounter #(
    parameter timer_pkg::bcd_t LIMIT = 4'd9,
    parameter timer_pkg::bcd_t INIT  = 4'd0
) (
    input  logic            clk,
    input  logic            rst_p,
    input  logic            load,
    input  logic            dec,
    output timer_pkg::bcd_t value,
    output logic            borrow
);

    logic at_floor;

    assign at_floor = (value == 4'd0);

    // Borrow in the same cycle as the wrap
    assign borrow = dec & at_floor;

    always_ff @(posedge clk) begin
        if (rst_p || load) begin
            value <= INIT;
        end else if (dec) begin
            if (at_floor) begin
                value <= LIMIT;
            end else begin
                value <= value - 4'd1;
            end
        end
    end

endmodule

//--- design/countdown_top.sv
`include "timer_defines.svh"

module countdown_top #(
    parameter int unsigned SEC_DIV    = `TIMER_SEC_DIV,
    parameter int unsigned SAMPLE_DIV = `TIMER_SAMPLE_DIV,
    parameter int unsigned SCAN_DIV   = `TIMER_SCAN_DIV
) (
    input  logic        clk,
    input  logic        rst_p,
    input  logic        pb_start,
    input  logic        pb_clear,
    output logic [7:0]  seg,
    output logic [3:0]  dis,
    output logic [15:0] led
);

    import timer_pkg::*;

    logic sec_tick;
    logic sample_tick;
    logic scan_tick;
    logic start_press;
    logic clear_press;
    logic running;
    logic borrow;
    logic at_zero;
    bcd_t tens;
    bcd_t ones;
    led_t led_bank;

    //////////////////////////////
    // Strobes and buttons
    //////////////////////////////

    tick_gen #(
        .SEC_DIV   (SEC_DIV),
        .SAMPLE_DIV(SAMPLE_DIV),
        .SCAN_DIV  (SCAN_DIV)
    ) u_tick_gen (
        .clk        (clk),
        .rst_p      (rst_p),
        .sec_tick   (sec_tick),
        .sample_tick(sample_tick),
        .scan_tick  (scan_tick)
    );

    button_cond u_start_btn (
        .clk        (clk),
        .rst_p      (rst_p),
        .sample_tick(sample_tick),
        .pb         (pb_start),
        .press      (start_press)
    );

    button_cond u_clear_btn (
        .clk        (clk),
        .rst_p      (rst_p),
        .sample_tick(sample_tick),
        .pb         (pb_clear),
        .press      (clear_press)
    );

    run_ctrl u_run_ctrl (
        .clk        (clk),
        .rst_p      (rst_p),
        .start_press(start_press),
        .clear_press(clear_press),
        .at_zero    (at_zero),
        .running    (running)
    );

    //////////////////////////////
    // Countdown digits
    //////////////////////////////

    bcd_downcounter #(
        .LIMIT(bcd_t'(9)),
        .INIT (bcd_t'(`TIMER_START_ONES))
    ) u_ones (
        .clk   (clk),
        .rst_p (rst_p),
        .load  (clear_press),
        .dec   (running & sec_tick),
        .value (ones),
        .borrow(borrow)
    );

    // Tens borrow output is left open, it never wraps from 3
    bcd_downcounter #(
        .LIMIT(bcd_t'(2)),
        .INIT (bcd_t'(`TIMER_START_TENS))
    ) u_tens (
        .clk   (clk),
        .rst_p (rst_p),
        .load  (clear_press),
        .dec   (borrow),
        .value (tens),
        .borrow()
    );

    seg_scan u_seg_scan (
        .clk      (clk),
        .rst_p    (rst_p),
        .scan_tick(scan_tick),
        .digit1   (tens),
        .digit0   (ones),
        .seg      (seg),
        .dis      (dis)
    );

    assign at_zero = (tens == 4'd0) && (ones == 4'd0);

    // All LEDs at zero, else bit 0 shows the run state
    always_comb begin
        if (at_zero) begin
            led_bank = '1;
        end else begin
            led_bank = led_t'(running);
        end
    end

    assign led = led_bank;

endmodule

//--- design/run_ctrl.sv
module run_ctrl (
    input  logic clk,
    input  logic rst_p,
    input  logic start_press,
    input  logic clear_press,
    input  logic at_zero,
    output logic running
);

    import timer_pkg::*;

    run_state_t state;
    run_state_t state_next;

    always_comb begin
        state_next = state;
        if (clear_press) begin
            state_next = IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start_press) state_next = RUN;
                end
                RUN: begin
                    // Reaching zero wins over a pause request
                    if (at_zero) begin
                        state_next = DONE;
                    end else if (start_press) begin
                        state_next = PAUSE;
                    end
                end
                PAUSE: begin
                    if (start_press) state_next = RUN;
                end
                default: state_next = DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_p) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign running = (state == RUN);

endmodule

//--- design/tick_gen.sv
`include "timer_defines.svh"

module tick_gen #(
    parameter int unsigned SEC_DIV    = `TIMER_SEC_DIV,
    parameter int unsigned SAMPLE_DIV = `TIMER_SAMPLE_DIV,
    parameter int unsigned SCAN_DIV   = `TIMER_SCAN_DIV
) (
    input  logic clk,
    input  logic rst_p,
    output logic sec_tick,
    output logic sample_tick,
    output logic scan_tick
);

    // Index 0 second, 1 sample, 2 scan
    localparam int unsigned DIV [3] = '{SEC_DIV, SAMPLE_DIV, SCAN_DIV};

    logic [31:0] cnt [3];
    logic [2:0]  tick;

    // Down-counters, reload on zero
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (rst_p || cnt[i] == '0) begin
                cnt[i] <= DIV[i] - 1;
            end else begin
                cnt[i] <= cnt[i] - 1;
            end
        end
    end

    // Strobe marks the reload cycle
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tick[i] = (cnt[i] == '0);
        end
    end

    assign sec_tick    = tick[0];
    assign sample_tick = tick[1];
    assign scan_tick   = tick[2];

endmodule

//--- display/seg_scan.sv
module seg_scan (
    input  logic            clk,
    input  logic            rst_p,
    input  logic            scan_tick,
    input  timer_pkg::bcd_t digit1,
    input  timer_pkg::bcd_t digit0,
    output timer_pkg::seg_t seg,
    output timer_pkg::dis_t dis
);

    import timer_pkg::*;

    logic [1:0] sel;
    bcd_t       shown;

    // Digit select rotation
    always_ff @(posedge clk) begin
        if (rst_p) begin
            sel <= 2'd0;
        end else if (scan_tick) begin
            sel <= sel + 2'd1;
        end
    end

    assign dis = ~(dis_t'(1) << sel);

    // Upper two digits are always blank zeros
    always_comb begin
        case (sel)
            2'd0:    shown = digit0;
            2'd1:    shown = digit1;
            default: shown = 4'd0;
        endcase
    end

    //////////////////////////////
    // Segment decode
    //////////////////////////////

    // Bit 7 is segment a, bit 0 is dp
    always_comb begin
        case (shown)
            4'd0:    seg = 8'h03;
            4'd1:    seg = 8'h9f;
            4'd2:    seg = 8'h25;
            4'd3:    seg = 8'h0d;
            4'd4:    seg = 8'h99;
            4'd5:    seg = 8'h49;
            4'd6:    seg = 8'h41;
            4'd7:    seg = 8'h1f;
            4'd8:    seg = 8'h01;
            4'd9:    seg = 8'h09;
            default: seg = 8'hff;
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module countdown_tb -f all.f -Mdir obj_dir

sim_out=$(./obj_dir/Vcountdown_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

//--- sim/countdown_props.sv
module countdown_props (
    input logic                  clk,
    input logic                  rst_p,
    input logic                  sec_tick,
    input logic                  sample_tick,
    input logic                  scan_tick,
    input logic                  start_press,
    input logic                  clear_press,
    input logic                  running,
    input timer_pkg::run_state_t state,
    input timer_pkg::bcd_t       tens,
    input timer_pkg::bcd_t       ones,
    input timer_pkg::led_t       led
);

    timeunit 1ns;
    timeprecision 100ps;

    import timer_pkg::*;

    //////////////////////////////
    // Single-cycle pulses
    //////////////////////////////

    a_sec_tick: assert property (@(posedge clk) disable iff (rst_p) sec_tick |=> !sec_tick)
        else $error("sec_tick high for more than one cycle");
    a_sample_tick: assert property (@(posedge clk) disable iff (rst_p)
        sample_tick |=> !sample_tick)
        else $error("sample_tick high for more than one cycle");
    a_scan_tick: assert property (@(posedge clk) disable iff (rst_p) scan_tick |=> !scan_tick)
        else $error("scan_tick high for more than one cycle");
    a_start_press: assert property (@(posedge clk) disable iff (rst_p)
        start_press |=> !start_press)
        else $error("start press pulse longer than one cycle");
    a_clear_press: assert property (@(posedge clk) disable iff (rst_p)
        clear_press |=> !clear_press)
        else $error("clear press pulse longer than one cycle");

    // Reaching 00 stops the count in DONE
    a_done_stopped: assert property (@(posedge clk) disable iff (rst_p)
        (tens == 4'd0 && ones == 4'd0 && !clear_press) |=> (state == DONE && !running))
        else $error("count at 00 did not stop in DONE");

    // Digits and LEDs hold at 00 until a clear
    a_led_zero: assert property (@(posedge clk) disable iff (rst_p)
        (tens == 4'd0 && ones == 4'd0 && !clear_press)
        |=> (tens == 4'd0 && ones == 4'd0 && led == '1))
        else $error("count or LED bank left 00 without a clear press");

endmodule

bind countdown_top countdown_props u_props (
    .clk        (clk),
    .rst_p      (rst_p),
    .sec_tick   (sec_tick),
    .sample_tick(sample_tick),
    .scan_tick  (scan_tick),
    .start_press(start_press),
    .clear_press(clear_press),
    .running    (running),
    .state      (u_run_ctrl.state),
    .tens       (tens),
    .ones       (ones),
    .led        (led)
);

//--- sim/countdown_tb.sv
`include "timer_defines.svh"

module countdown_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import timer_pkg::*;

    localparam int SEC_DIV     = 64;
    localparam int SAMPLE_DIV  = 2;
    localparam int SCAN_DIV    = 3;
    localparam int HOLD_CYC    = 12;
    localparam int CHECK_PHASE = 36;

    typedef enum logic [1:0] {ACT_WAIT, ACT_START, ACT_CLEAR} act_t;

    typedef struct packed {
        act_t       act;
        logic [7:0] secs;
        bcd_t       tens;
        bcd_t       ones;
        led_t       led;
    } row_t;

    logic        clk;
    logic        rst_p;
    logic        pb_start;
    logic        pb_clear;
    seg_t        seg;
    dis_t        dis;
    led_t        led;
    row_t        rows [$];
    logic [31:0] lfsr_state;
    int          sec_phase;
    int          cycle_count;
    int          cycle_limit;
    int          m_tens;
    int          m_ones;
    run_state_t  m_state;

    countdown_top #(
        .SEC_DIV   (SEC_DIV),
        .SAMPLE_DIV(SAMPLE_DIV),
        .SCAN_DIV  (SCAN_DIV)
    ) i_dut (
        .clk     (clk),
        .rst_p   (rst_p),
        .pb_start(pb_start),
        .pb_clear(pb_clear),
        .seg     (seg),
        .dis     (dis),
        .led     (led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycles since the digits last moved
    always @(posedge clk) begin
        if (rst_p || sec_phase == SEC_DIV - 1) begin
            sec_phase <= 0;
        end else begin
            sec_phase <= sec_phase + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    task automatic wait_phase(input int p);
        do begin
            @(posedge clk);
            #1;
        end while (sec_phase != p);
    endtask

    task automatic press_button(input bit clear);
        int release_cyc;
        release_cyc = HOLD_CYC + take_bits(3);
        if (clear) begin
            pb_clear = 1'b1;
        end else begin
            pb_start = 1'b1;
        end
        repeat (HOLD_CYC) begin
            @(posedge clk);
            #1;
        end
        pb_start = 1'b0;
        pb_clear = 1'b0;
        repeat (release_cyc) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // Table and reference model
    //////////////////////////////

    task automatic add_row(input act_t act, input int secs);
        row_t r;
        r = '0;
        r.act = act;
        r.secs = 8'(secs);
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(ACT_WAIT, 2);
        add_row(ACT_START, 0);
        add_row(ACT_WAIT, 3);
        add_row(ACT_START, 0);
        add_row(ACT_WAIT, 2);
        add_row(ACT_START, 0);
        // Crosses 20 while running
        add_row(ACT_WAIT, 9);
        add_row(ACT_CLEAR, 0);
        add_row(ACT_START, 0);
        // Runs out and stops at 00
        add_row(ACT_WAIT, 31);
        add_row(ACT_START, 0);
        add_row(ACT_WAIT, 2);
        add_row(ACT_CLEAR, 0);
        add_row(ACT_START, 0);
        add_row(ACT_WAIT, 21);
    endtask

    // One second of the countdown
    task automatic model_second();
        if (m_state == RUN) begin
            if (m_ones == 0) begin
                m_ones = 9;
                m_tens = m_tens - 1;
            end else begin
                m_ones = m_ones - 1;
            end
            if (m_tens == 0 && m_ones == 0) begin
                m_state = DONE;
            end
        end
    endtask

    function automatic led_t model_led();
        if (m_tens == 0 && m_ones == 0) begin
            return '1;
        end
        return led_t'(m_state == RUN);
    endfunction

    // Press rows also cross one second boundary before the press
    task automatic fill_expected();
        row_t r;
        m_tens = `TIMER_START_TENS;
        m_ones = `TIMER_START_ONES;
        m_state = IDLE;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.act == ACT_WAIT) begin
                repeat (int'(r.secs)) model_second();
            end else begin
                model_second();
            end
            if (r.act == ACT_CLEAR) begin
                m_tens = `TIMER_START_TENS;
                m_ones = `TIMER_START_ONES;
                m_state = IDLE;
            end else if (r.act == ACT_START) begin
                case (m_state)
                    IDLE:    m_state = RUN;
                    RUN:     m_state = PAUSE;
                    PAUSE:   m_state = RUN;
                    DONE:    m_state = DONE;
                endcase
            end
            r.tens = bcd_t'(m_tens);
            r.ones = bcd_t'(m_ones);
            r.led = model_led();
            rows[i] = r;
        end
    endtask

    //////////////////////////////
    // Display reader and checks
    //////////////////////////////

    task automatic check_bcd(input string name, input bcd_t got, input bcd_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "digit mismatch");
        end
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "led mismatch");
        end
    endtask

    // Decodes lit segments a..g and requires a dark dp
    function automatic bit seg_to_digit(input seg_t s, output bcd_t d);
        logic [6:0] lit;
        lit = ~s[7:1];
        seg_to_digit = (s[0] === 1'b1);
        case (lit)
            7'h7e:   d = 4'd0;
            7'h30:   d = 4'd1;
            7'h6d:   d = 4'd2;
            7'h79:   d = 4'd3;
            7'h33:   d = 4'd4;
            7'h5b:   d = 4'd5;
            7'h5f:   d = 4'd6;
            7'h70:   d = 4'd7;
            7'h7f:   d = 4'd8;
            7'h7b:   d = 4'd9;
            default: begin
                d = 4'hf;
                seg_to_digit = 1'b0;
            end
        endcase
    endfunction

    task automatic read_display(output bcd_t tens, output bcd_t ones);
        bcd_t shown [4];
        dis_t want;
        int   d;
        for (d = 0; d < 4; d++) begin
            // Only the enable of digit d is low
            want = '1;
            want[d] = 1'b0;
            while (dis !== want) begin
                @(posedge clk);
                #1;
            end
            if (!seg_to_digit(seg, shown[d])) begin
                $display("Digit %0d shows segment pattern %h, which is not a digit", d, seg);
                $display("FAIL: see errors above");
                $fatal(1, "bad segment pattern");
            end
        end
        check_bcd("digit3", shown[3], 4'd0);
        check_bcd("digit2", shown[2], 4'd0);
        tens = shown[1];
        ones = shown[0];
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        bcd_t tens;
        bcd_t ones;
        row_t r;
        int   total_secs;
        int   presses;
        pb_start = 1'b0;
        pb_clear = 1'b0;
        rst_p = 1'b1;
        lfsr_state = 32'hf29aec3b;
        build_table();
        fill_expected();
        total_secs = 2;
        presses = 0;
        foreach (rows[i]) begin
            if (rows[i].act == ACT_WAIT) begin
                total_secs += int'(rows[i].secs);
            end else begin
                total_secs += 1;
                presses += 1;
            end
        end
        cycle_limit = total_secs * SEC_DIV + presses * (2 * HOLD_CYC + 8) + 200;

        repeat (8) @(posedge clk);
        #1;
        rst_p = 1'b0;
        wait_phase(32);
        read_display(tens, ones);
        check_bcd("tens after reset", tens, bcd_t'(`TIMER_START_TENS));
        check_bcd("ones after reset", ones, bcd_t'(`TIMER_START_ONES));
        check_led("led after reset", led, '0);

        foreach (rows[i]) begin
            r = rows[i];
            if (r.act == ACT_WAIT) begin
                repeat (int'(r.secs)) wait_phase(1);
            end else begin
                wait_phase(1);
                press_button(r.act == ACT_CLEAR);
            end
            wait_phase(CHECK_PHASE);
            read_display(tens, ones);
            check_bcd($sformatf("row %0d tens", i), tens, r.tens);
            check_bcd($sformatf("row %0d ones", i), ones, r.ones);
            check_led($sformatf("row %0d led", i), led, r.led);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
